/* hdl/rvIsaPkg.sv */
package rvIsaPkg;

  // ==============================
  // Basic word types
  // ==============================
  typedef logic [31:0] wordT;     // Data and address word
  typedef logic [4:0]  regAddrT;  // x0..x31
  typedef logic [31:0] instrT;
  typedef logic [6:0]  opcodeT;
  typedef logic [2:0]  funct3T;

  // ==============================
  // Opcodes of the supported subset
  // ==============================
  localparam opcodeT OP_RTYPE = 7'b0110011;  // add sub and or slt
  localparam opcodeT OP_ITYPE = 7'b0010011;  // addi andi ori slti
  localparam opcodeT OP_LOAD  = 7'b0000011;  // lw
  localparam opcodeT OP_STORE = 7'b0100011;  // sw

  // funct3 codes, shared by R and I forms
  localparam funct3T F3_ADDSUB = 3'b000;
  localparam funct3T F3_SLT    = 3'b010;
  localparam funct3T F3_OR     = 3'b110;
  localparam funct3T F3_AND    = 3'b111;

  // ==============================
  // Field positions in the instruction word
  // ==============================
  localparam int OPC_LSB = 0;   // opcode[6:0]
  localparam int RD_LSB  = 7;   // rd, also imm[4:0] of S-type
  localparam int F3_LSB  = 12;
  localparam int RS1_LSB = 15;
  localparam int RS2_LSB = 20;
  localparam int SUB_BIT = 30;  // funct7[5], sub vs add

endpackage

/* hdl/rvPipePkg.sv */
package rvPipePkg;

  // ==============================
  // ALU control
  // ==============================
  typedef logic [2:0] aluCtrlT;

  localparam aluCtrlT ALU_ADD = 3'b000;
  localparam aluCtrlT ALU_SUB = 3'b001;
  localparam aluCtrlT ALU_AND = 3'b010;
  localparam aluCtrlT ALU_OR  = 3'b011;
  localparam aluCtrlT ALU_SLT = 3'b101;  // Signed compare

  // Write-back source
  typedef logic resultSrcT;

  localparam resultSrcT RES_ALU = 1'b0;
  localparam resultSrcT RES_MEM = 1'b1;  // Also marks a load in flight

  // ==============================
  // Operand forwarding select
  // ==============================
  typedef logic [1:0] fwdSelT;

  localparam fwdSelT FWD_REG = 2'b00;  // Value read in decode
  localparam fwdSelT FWD_WB  = 2'b01;  // From writeback
  localparam fwdSelT FWD_MEM = 2'b10;  // From memory stage, wins over WB

endpackage

/* hdl/regFile.sv */
`timescale 1ns/1ps

module regFile (
  input  logic              clk,
  input  rvIsaPkg::regAddrT readAddr1,
  input  rvIsaPkg::regAddrT readAddr2,
  input  rvIsaPkg::regAddrT writeAddr,
  input  logic              writeEn,
  input  rvIsaPkg::wordT    writeData,
  output rvIsaPkg::wordT    readData1,
  output rvIsaPkg::wordT    readData2
);
  import rvIsaPkg::*;

  wordT regs [32];

  // Falling-edge write
  // decode reads in the second half of the cycle and sees the new value
  always_ff @(negedge clk) begin
    if (writeEn) begin
      regs[writeAddr] <= writeData;
    end
  end

  // x0 hardwired to zero, whatever was written there
  assign readData1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
  assign readData2 = (readAddr2 == '0) ? '0 : regs[readAddr2];

endmodule

/* hdl/instrDecode.sv */
`timescale 1ns/1ps

module instrDecode #(
  parameter int bufDepth = 2
) (
  input  logic                  clk,
  input  logic                  reset,
  input  rvIsaPkg::instrT       instr,
  input  logic                  instrValid,
  input  rvIsaPkg::regAddrT     rdW,
  input  logic                  regWriteW,
  input  rvIsaPkg::wordT        resultW,
  output logic                  creditReturn,
  output rvIsaPkg::wordT        srcAE,
  output rvIsaPkg::wordT        srcBRegE,
  output rvIsaPkg::wordT        immE,
  output rvIsaPkg::regAddrT     rs1E,
  output rvIsaPkg::regAddrT     rs2E,
  output rvIsaPkg::regAddrT     rdE,
  output rvPipePkg::aluCtrlT    aluCtrlE,
  output logic                  aluSrcImmE,
  output logic                  regWriteE,
  output logic                  memWriteE,
  output rvPipePkg::resultSrcT  resultSrcE
);
  import rvIsaPkg::*;
  import rvPipePkg::*;

  localparam int ptrW = (bufDepth > 1) ? $clog2(bufDepth) : 1;
  localparam int cntW = $clog2(bufDepth + 1);

  instrT           bufMem [bufDepth];  // Sender never overruns, credits see to it
  logic [ptrW-1:0] headPtr, tailPtr;
  logic [cntW-1:0] bufCount;           // Occupancy
  logic            headValid, loadUse, advance;

  instrT     headInstr;
  opcodeT    opcode;
  funct3T    funct3;
  regAddrT   rs1D, rs2D, rdD;
  wordT      immD, readData1, readData2;
  aluCtrlT   aluCtrlD;
  logic      aluSrcImmD, regWriteD, memWriteD;
  resultSrcT resultSrcD;

  function automatic logic [ptrW-1:0] ptrInc(input logic [ptrW-1:0] ptr);
    if (ptr == ptrW'(bufDepth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // ==============================
  // Instruction buffer
  // ==============================
  always_ff @(posedge clk) begin
    if (instrValid) begin
      bufMem[tailPtr] <= instr;  // Every valid is taken
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      headPtr  <= '0;
      tailPtr  <= '0;
      bufCount <= '0;
    end else begin
      if (instrValid) begin
        tailPtr <= ptrInc(tailPtr);
      end
      if (advance) begin
        headPtr <= ptrInc(headPtr);
      end
      bufCount <= bufCount + cntW'(instrValid) - cntW'(advance);
    end
  end

  // ==============================
  // Head decode
  // ==============================
  assign headInstr = bufMem[headPtr];
  assign opcode    = headInstr[OPC_LSB +: 7];
  assign funct3    = headInstr[F3_LSB +: 3];
  assign rdD       = headInstr[RD_LSB +: 5];
  assign rs1D      = headInstr[RS1_LSB +: 5];
  assign rs2D      = headInstr[RS2_LSB +: 5];

  // Main control, unknown opcodes fall through as no-ops
  always_comb begin
    regWriteD  = 1'b0;
    memWriteD  = 1'b0;
    aluSrcImmD = 1'b1;
    resultSrcD = RES_ALU;
    case (opcode)
      OP_RTYPE: begin
        regWriteD  = 1'b1;
        aluSrcImmD = 1'b0;
      end
      OP_ITYPE: regWriteD = 1'b1;
      OP_LOAD: begin
        regWriteD  = 1'b1;
        resultSrcD = RES_MEM;
      end
      OP_STORE: memWriteD = 1'b1;
      default: aluSrcImmD = 1'b0;
    endcase
  end

  // ALU control, address math is a plain add
  always_comb begin
    aluCtrlD = ALU_ADD;
    if (opcode == OP_RTYPE || opcode == OP_ITYPE) begin
      case (funct3)
        F3_ADDSUB: begin
          // Only R-type has sub, addi reuses bit 30 as immediate
          if (opcode == OP_RTYPE && headInstr[SUB_BIT]) begin
            aluCtrlD = ALU_SUB;
          end
        end
        F3_SLT:  aluCtrlD = ALU_SLT;
        F3_OR:   aluCtrlD = ALU_OR;
        F3_AND:  aluCtrlD = ALU_AND;
        default: aluCtrlD = ALU_ADD;
      endcase
    end
  end

  // Sign-extended immediate, S-type split field for stores
  assign immD = (opcode == OP_STORE) ?
                {{20{headInstr[31]}}, headInstr[31:25], headInstr[11:7]} :
                {{20{headInstr[31]}}, headInstr[31:20]};

  regFile regFile_inst (
    .clk       (clk),
    .readAddr1 (rs1D),
    .readAddr2 (rs2D),
    .writeAddr (rdW),
    .writeEn   (regWriteW),
    .writeData (resultW),
    .readData1 (readData1),
    .readData2 (readData2)
  );

  // ==============================
  // Stall and decode-to-execute register
  // ==============================
  // Load in execute and head reads its rd, wait one cycle
  assign headValid    = (bufCount != '0);
  assign loadUse      = (resultSrcE == RES_MEM) && (rdE != '0) &&
                        ((rs1D == rdE) || (rs2D == rdE));
  assign advance      = headValid && !loadUse;
  assign creditReturn = advance;  // One credit per instruction leaving

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      regWriteE  <= 1'b0;
      memWriteE  <= 1'b0;
      resultSrcE <= RES_ALU;
    end else begin
      regWriteE  <= advance && regWriteD;  // Bubble on stall
      memWriteE  <= advance && memWriteD;
      resultSrcE <= advance ? resultSrcD : RES_ALU;
    end
  end

  // Payload follows the head, only meaningful with control set
  always_ff @(posedge clk) begin
    srcAE      <= readData1;
    srcBRegE   <= readData2;
    immE       <= immD;
    rs1E       <= rs1D;
    rs2E       <= rs2D;
    rdE        <= rdD;
    aluCtrlE   <= aluCtrlD;
    aluSrcImmE <= aluSrcImmD;
  end

endmodule

/* hdl/intExecute.sv */
`timescale 1ns/1ps

module intExecute (
  input  logic                  clk,
  input  logic                  reset,
  input  rvIsaPkg::wordT        srcAE,
  input  rvIsaPkg::wordT        srcBRegE,
  input  rvIsaPkg::wordT        immE,
  input  rvIsaPkg::regAddrT     rs1E,
  input  rvIsaPkg::regAddrT     rs2E,
  input  rvIsaPkg::regAddrT     rdE,
  input  rvPipePkg::aluCtrlT    aluCtrlE,
  input  logic                  aluSrcImmE,
  input  logic                  regWriteE,
  input  logic                  memWriteE,
  input  rvPipePkg::resultSrcT  resultSrcE,
  input  rvIsaPkg::wordT        resultW,
  input  rvIsaPkg::regAddrT     rdW,
  input  logic                  regWriteW,
  output rvIsaPkg::wordT        aluResultM,
  output rvIsaPkg::wordT        writeDataM,
  output rvIsaPkg::regAddrT     rdM,
  output logic                  regWriteM,
  output logic                  memWriteM,
  output rvPipePkg::resultSrcT  resultSrcM
);
  import rvIsaPkg::*;
  import rvPipePkg::*;

  fwdSelT fwdA, fwdB;
  wordT   opA, opBReg, opB, aluResult;

  // Memory stage first, it holds the younger result
  function automatic fwdSelT fwdPick(input regAddrT rs, input regAddrT rdMem,
                                     input logic wrMem, input regAddrT rdWb,
                                     input logic wrWb);
    if (rs == '0) begin
      return FWD_REG;  // x0 stays zero
    end
    if (wrMem && rdMem == rs) begin
      return FWD_MEM;
    end
    if (wrWb && rdWb == rs) begin
      return FWD_WB;
    end
    return FWD_REG;
  endfunction

  // ==============================
  // Forwarding
  // ==============================
  assign fwdA = fwdPick(rs1E, rdM, regWriteM, rdW, regWriteW);
  assign fwdB = fwdPick(rs2E, rdM, regWriteM, rdW, regWriteW);

  assign opA    = (fwdA == FWD_MEM) ? aluResultM :
                  (fwdA == FWD_WB)  ? resultW : srcAE;
  assign opBReg = (fwdB == FWD_MEM) ? aluResultM :
                  (fwdB == FWD_WB)  ? resultW : srcBRegE;
  assign opB    = aluSrcImmE ? immE : opBReg;  // Store data keeps opBReg

  // ==============================
  // ALU
  // ==============================
  always_comb begin
    case (aluCtrlE)
      ALU_ADD: aluResult = opA + opB;
      ALU_SUB: aluResult = opA - opB;
      ALU_AND: aluResult = opA & opB;
      ALU_OR:  aluResult = opA | opB;
      ALU_SLT: aluResult = {31'b0, $signed(opA) < $signed(opB)};
      default: aluResult = opA + opB;
    endcase
  end

  // Execute-to-memory register
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      regWriteM  <= 1'b0;
      memWriteM  <= 1'b0;
      resultSrcM <= RES_ALU;
    end else begin
      regWriteM  <= regWriteE;
      memWriteM  <= memWriteE;
      resultSrcM <= resultSrcE;
    end
  end

  always_ff @(posedge clk) begin
    aluResultM <= aluResult;  // Also the load/store address
    writeDataM <= opBReg;
    rdM        <= rdE;
  end

endmodule

/* hdl/memResult.sv */
`timescale 1ns/1ps

module memResult #(
  parameter int dmemWords = 64
) (
  input  logic                  clk,
  input  logic                  reset,
  input  rvIsaPkg::wordT        aluResultM,
  input  rvIsaPkg::wordT        writeDataM,
  input  rvIsaPkg::regAddrT     rdM,
  input  logic                  regWriteM,
  input  logic                  memWriteM,
  input  rvPipePkg::resultSrcT  resultSrcM,
  output rvIsaPkg::wordT        resultW,
  output rvIsaPkg::regAddrT     rdW,
  output logic                  regWriteW
);
  import rvIsaPkg::*;
  import rvPipePkg::*;

  localparam int addrW = (dmemWords > 1) ? $clog2(dmemWords) : 1;

  wordT       dmem [dmemWords];
  logic [addrW-1:0] wordIdx;
  wordT       readDataM, aluResultW, readDataW;
  resultSrcT  resultSrcW;

  // ==============================
  // Data memory
  // ==============================
  initial begin
    for (int i = 0; i < dmemWords; i++) begin
      dmem[i] = '0;
    end
  end

  assign wordIdx   = aluResultM[addrW+1:2];  // Byte address to word, low bits dropped
  assign readDataM = dmem[wordIdx];          // Combinational read

  always_ff @(posedge clk) begin
    if (memWriteM) begin
      dmem[wordIdx] <= writeDataM;
    end
  end

  // ==============================
  // Memory-to-writeback register
  // ==============================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      regWriteW  <= 1'b0;
      resultSrcW <= RES_ALU;
    end else begin
      regWriteW  <= regWriteM;
      resultSrcW <= resultSrcM;
    end
  end

  always_ff @(posedge clk) begin
    aluResultW <= aluResultM;
    readDataW  <= readDataM;
    rdW        <= rdM;
  end

  assign resultW = (resultSrcW == RES_MEM) ? readDataW : aluResultW;

endmodule

/* hdl/rvCore.sv */
`timescale 1ns/1ps

module rvCore #(
  parameter int bufDepth  = 2,   // Also the sender's credits after reset
  parameter int dmemWords = 64
) (
  input  logic            clk,
  input  logic            reset,
  input  rvIsaPkg::instrT instr,
  input  logic            instrValid,
  output logic            creditReturn,
  output logic            memWrite,
  output rvIsaPkg::wordT  dataAddr,
  output rvIsaPkg::wordT  writeData
);
  import rvIsaPkg::*;
  import rvPipePkg::*;

  // Decode to execute
  wordT      srcAE, srcBRegE, immE;
  regAddrT   rs1E, rs2E, rdE;
  aluCtrlT   aluCtrlE;
  logic      aluSrcImmE, regWriteE, memWriteE;
  resultSrcT resultSrcE;

  // Execute to memory, store side goes straight out
  regAddrT   rdM;
  logic      regWriteM;
  resultSrcT resultSrcM;

  // Writeback, back to decode and forwarding
  wordT      resultW;
  regAddrT   rdW;
  logic      regWriteW;

  // ==============================
  instrDecode #(.bufDepth(bufDepth)) instrDecode_inst (
    .clk(clk), .reset(reset), .instr(instr), .instrValid(instrValid),
    .rdW(rdW), .regWriteW(regWriteW), .resultW(resultW), .creditReturn(creditReturn),
    .srcAE(srcAE), .srcBRegE(srcBRegE), .immE(immE),
    .rs1E(rs1E), .rs2E(rs2E), .rdE(rdE), .aluCtrlE(aluCtrlE), .aluSrcImmE(aluSrcImmE),
    .regWriteE(regWriteE), .memWriteE(memWriteE), .resultSrcE(resultSrcE)
  );

  intExecute intExecute_inst (
    .clk(clk), .reset(reset), .srcAE(srcAE), .srcBRegE(srcBRegE), .immE(immE),
    .rs1E(rs1E), .rs2E(rs2E), .rdE(rdE), .aluCtrlE(aluCtrlE), .aluSrcImmE(aluSrcImmE),
    .regWriteE(regWriteE), .memWriteE(memWriteE), .resultSrcE(resultSrcE),
    .resultW(resultW), .rdW(rdW), .regWriteW(regWriteW),
    .aluResultM(dataAddr), .writeDataM(writeData), .rdM(rdM),
    .regWriteM(regWriteM), .memWriteM(memWrite), .resultSrcM(resultSrcM)
  );

  memResult #(.dmemWords(dmemWords)) memResult_inst (
    .clk(clk), .reset(reset), .aluResultM(dataAddr), .writeDataM(writeData),
    .rdM(rdM), .regWriteM(regWriteM), .memWriteM(memWrite), .resultSrcM(resultSrcM),
    .resultW(resultW), .rdW(rdW), .regWriteW(regWriteW)
  );

endmodule

/* verif/rvCoreChk_chk.sv */
`timescale 1ns/1ps

module rvCoreChk #(
  parameter int bufDepth = 2,
  parameter int cntW     = 2
) (
  input logic            clk,
  input logic            reset,
  input logic [cntW-1:0] bufCount,
  input logic            instrValid,
  input logic            creditReturn,
  input logic            memWriteE
);

  logic [cntW-1:0] held;  // Accepted at the port, credit not yet back

  // Occupancy as the sender sees it, from port events only
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      held <= '0;
    end else begin
      held <= held + cntW'(instrValid) - cntW'(creditReturn);
    end
  end

  // Sender overrun shows up as occupancy past the depth
  bufNoOverflow: assert property (@(posedge clk) disable iff (reset)
    bufCount <= cntW'(bufDepth))
    else $error("Instruction buffer holds %0d entries, limit %0d", bufCount, bufDepth);

  creditNeedsEntry: assert property (@(posedge clk) disable iff (reset)
    creditReturn |-> held != '0)  // Credit only for an entry taken earlier
    else $error("Credit returned with no accepted instruction outstanding");

  // memWrite is memWriteE one stage later
  quietAfterReset: assert property (@(posedge clk) $fell(reset) |-> !memWriteE)
    else $error("Store enable set in the first cycle after reset");

endmodule

bind instrDecode rvCoreChk #(.bufDepth(bufDepth), .cntW(cntW)) rvCoreChk_inst (
  .clk(clk), .reset(reset), .bufCount(bufCount), .instrValid(instrValid),
  .creditReturn(creditReturn), .memWriteE(memWriteE)
);

/* verif/rvCoreTb.sv */
`timescale 1ns/1ps

module rvCoreTb;
  import rvIsaPkg::*;

  localparam int bufDepth  = 2;
  localparam int dmemWords = 64;
  localparam int progLen   = 200;
  localparam int numTests  = 4;
  localparam int seed      = 20;

  logic  clk, reset, instrValid, creditReturn, memWrite;
  instrT instr;
  wordT  dataAddr, writeData;

  instrT  prog [progLen];
  wordT   mRegs [32];         // ISA model registers, only x0..x7 used
  wordT   mMem [dmemWords];   // ISA model data memory
  wordT   expAddrQ [$];
  wordT   expDataQ [$];
  int     credits;            // Sender side
  int     errors, checks, testErrors, testChecks;
  int     idlePct [numTests] = '{30, 0, 70, 0};  // 0 means every credit used at once
  funct3T f3Pick [4] = '{F3_ADDSUB, F3_SLT, F3_OR, F3_AND};

  rvCore #(.bufDepth(bufDepth), .dmemWords(dmemWords)) rvCore_inst (
    .clk(clk), .reset(reset), .instr(instr), .instrValid(instrValid),
    .creditReturn(creditReturn), .memWrite(memWrite),
    .dataAddr(dataAddr), .writeData(writeData)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Watchdog, six cycles per instruction is far above the worst case
  initial begin
    repeat (numTests * progLen * 6 + 100) @(posedge clk);
    $display("Timeout: run did not finish within %0d clock periods",
             numTests * progLen * 6 + 100);
    $display("SOME TESTS FAILED");
    $finish;
  end

  // ==============================
  // ISA model
  // ==============================
  function automatic wordT sext12(input logic [11:0] imm);
    return {{20{imm[11]}}, imm};
  endfunction

  function automatic wordT aluOp(input funct3T f3, input logic sub, input wordT a,
                                 input wordT b);
    case (f3)
      F3_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      F3_OR:   return a | b;
      F3_AND:  return a & b;
      default: return sub ? a - b : a + b;
    endcase
  endfunction

  task automatic writeReg(input regAddrT rd, input wordT value);
    if (rd != '0) begin
      mRegs[rd] = value;  // x0 write dropped
    end
  endtask

  // sw rs2, w*4(x0)
  task automatic addStore(input int idx, input regAddrT rs2, input int w);
    logic [11:0] imm;
    imm = 12'(w * 4);
    prog[idx] = {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], OP_STORE};
    mMem[w] = mRegs[rs2];
    expAddrQ.push_back(wordT'(w * 4));
    expDataQ.push_back(mRegs[rs2]);
  endtask

  task automatic randomInstr(input int idx);
    funct3T      f3;
    regAddrT     rd, rs1, rs2;
    logic [11:0] imm;
    logic        sub;
    int          sel, w;
    f3  = f3Pick[$urandom % 4];
    rd  = 5'($urandom % 8);  // Few registers, dense hazards
    rs1 = 5'($urandom % 8);
    rs2 = 5'($urandom % 8);
    sel = int'($urandom % 100);
    w   = int'($urandom % dmemWords);
    if (sel < 40) begin
      sub = (f3 == F3_ADDSUB) && ($urandom % 2 == 1);
      prog[idx] = {1'b0, sub, 5'b0, rs2, rs1, f3, rd, OP_RTYPE};
      writeReg(rd, aluOp(f3, sub, mRegs[rs1], mRegs[rs2]));
    end else if (sel < 70) begin
      imm = 12'($urandom);
      prog[idx] = {imm, rs1, f3, rd, OP_ITYPE};
      writeReg(rd, aluOp(f3, 1'b0, mRegs[rs1], sext12(imm)));
    end else if (sel < 85) begin
      imm = 12'(w * 4);
      prog[idx] = {imm, 5'd0, 3'b010, rd, OP_LOAD};  // lw rd, w*4(x0)
      writeReg(rd, mMem[w]);
    end else begin
      addStore(idx, rs2, w);
    end
  endtask

  task automatic buildProgram();
    logic [11:0] imm;
    for (int i = 1; i < 8; i++) begin  // Known start values, addi xi, x0, imm
      imm = 12'($urandom);
      prog[i - 1] = {imm, 5'd0, F3_ADDSUB, 5'(i), OP_ITYPE};
      mRegs[i] = sext12(imm);
    end
    for (int i = 7; i < progLen - 7; i++) begin
      randomInstr(i);
    end
    for (int i = 1; i < 8; i++) begin
      addStore(progLen - 8 + i, 5'(i), i - 1);  // Final sweep of x1..x7
    end
  endtask

  // ==============================
  // Checks and driver
  // ==============================
  task automatic compareAddr(input wordT exp, input wordT act);
    if (act !== exp) begin
      $display("Mismatch dataAddr: expected %h, got %h", exp, act);
      testErrors++;
    end
  endtask

  task automatic compareData(input wordT exp, input wordT act);
    if (act !== exp) begin
      $display("Mismatch writeData: expected %h, got %h", exp, act);
      testErrors++;
    end
  endtask

  // One falling edge, outputs stable here
  task automatic stepCycle(output logic credit);
    @(negedge clk);
    credit     = creditReturn;
    instrValid = 1'b0;
    if (memWrite) begin
      testChecks++;
      if (expAddrQ.size() == 0) begin
        $display("Extra store to address %h after the program's last store", dataAddr);
        testErrors++;
      end else begin
        compareAddr(expAddrQ.pop_front(), dataAddr);
        compareData(expDataQ.pop_front(), writeData);
      end
    end
  endtask

  task automatic sendProgram(input int idle);
    logic credit;
    int   sent;
    sent = 0;
    while (sent < progLen) begin
      stepCycle(credit);
      if (credits > 0 && int'($urandom % 100) >= idle) begin
        instr      = prog[sent];
        instrValid = 1'b1;
        credits--;
        sent++;
      end
      if (credit) begin
        credits++;  // Usable from the next cycle on
      end
    end
  endtask

  task automatic drainPipe();
    logic credit;
    while (expAddrQ.size() > 0 || credits < bufDepth) begin
      stepCycle(credit);
      if (credit) begin
        credits++;
      end
    end
    repeat (4) begin  // Nothing may follow the last store
      stepCycle(credit);
      if (credit) begin
        credits++;
      end
    end
    if (credits != bufDepth) begin
      $display("Sender holds %0d credits after the test instead of %0d", credits, bufDepth);
      testErrors++;
    end
  endtask

  initial begin
    void'($urandom(seed));
    reset      = 1'b1;
    instrValid = 1'b0;
    instr      = '0;
    credits    = 0;
    errors     = 0;
    checks     = 0;
    foreach (mRegs[i]) mRegs[i] = '0;
    foreach (mMem[i]) mMem[i] = '0;  // DUT memory starts at zero too
    repeat (10) @(negedge clk);
    reset   = 1'b0;
    credits = bufDepth;
    for (int t = 0; t < numTests; t++) begin
      testErrors = 0;
      testChecks = 0;
      buildProgram();
      sendProgram(idlePct[t]);
      drainPipe();
      $display("Test %0d (idle %0d%%): %0d stores checked, %0d errors",
               t, idlePct[t], testChecks, testErrors);
      errors += testErrors;
      checks += testChecks;
    end
    $display("Tests: %0d, stores checked: %0d, errors: %0d", numTests, checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* sources.f */
hdl/rvIsaPkg.sv
hdl/rvPipePkg.sv
hdl/regFile.sv
hdl/instrDecode.sv
hdl/intExecute.sv
hdl/memResult.sv
hdl/rvCore.sv
verif/rvCoreChk_chk.sv
verif/rvCoreTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the rvCore testbench with Verilator
set -u
cd "$(dirname "$0")"

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert --top-module rvCoreTb \
  -f sources.f --Mdir "$buildDir" -o rvCoreSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$buildDir/rvCoreSim" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -q "SOME TESTS FAILED" "$logFile"; then
  exit 1
fi
exit 0
